//--- Bender.yml
package:
  name: irqc

sources:
  - common/irqc_pkg.sv
  - rtl/irqc_csr_port.sv
  - irq_regfile/irq_regfile.sv
  - irq_context/irq_context.sv
  - rtl/irq_select.sv
  - rtl/irqc_top.sv
  - target: test
    files:
      - verif/irqc_clkgen.sv
      - verif/irqc_checker.sv
      - verif/irqc_assertions.sv
      - verif/irqc_tb.sv

//--- common/irqc_pkg.sv
// -----------------------------------------------
// Shared types of the external interrupt controller
// Register addresses, request and response structs,
// write-data union and the preemption context
// -----------------------------------------------

`default_nettype none

package irqc_pkg;

	// -----------------------------------------------
	// Sizes

	// Width of every register word on the port
	localparam int unsigned data_w = 32;

	// Largest line count that a 7-bit window index can address
	// (128 priority windows of 4 lines each)
	localparam int unsigned max_irqs = 512;

	// -----------------------------------------------
	// Register addresses

	// Custom machine-mode registers of the controller
	typedef enum logic [11:0] {
		meiea      = 12'hbe0,
		meipa      = 12'hbe1,
		meifa      = 12'hbe2,
		meipra     = 12'hbe3,
		meinext    = 12'hbe4,
		meicontext = 12'hbe5
	} csr_addr_e;

	// -----------------------------------------------
	// Write data, seen in two ways

	// Array registers take a window of 16 bits in the upper half and
	// select the window with the index in the low bits
	typedef struct packed {
		logic [15:0] data;
		logic [8:0]  pad;
		logic [6:0]  index;
	} csr_win_t;

	// Layout of meicontext, which meinext shares for its update bit
	typedef struct packed {
		logic [3:0] pppreempt;
		logic [3:0] ppreempt;
		logic [2:0] pad_hi;
		logic [4:0] preempt;
		logic       noirq;
		logic [1:0] pad_mid;
		logic [8:0] irq;
		logic [2:0] pad_lo;
		// On a meinext write this bit is the update request
		logic       mreteirq;
	} csr_ctx_word_t;

	typedef union packed {
		csr_win_t      win;
		csr_ctx_word_t ctx;
	} csr_wdata_u;

	// -----------------------------------------------
	// Register port

	typedef struct packed {
		csr_addr_e  addr;
		logic       write;
		csr_wdata_u data;
	} csr_req_t;

	typedef struct packed {
		logic [data_w-1:0] rdata;
	} csr_rsp_t;

	// -----------------------------------------------
	// Preemption context

	// Three levels of saved priority plus the last sampled line
	typedef struct packed {
		logic [3:0] pppreempt;
		logic [3:0] ppreempt;
		logic [4:0] preempt;
		logic       noirq;
		logic [8:0] irq;
		logic       mreteirq;
	} irq_ctx_t;

endpackage

`default_nettype wire

//--- irq_context/irq_context.sv
// -----------------------------------------------
// Preemption context of the interrupt controller
// Save on trap entry, restore on trap exit, direct
// write and meinext update
// -----------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irq_context #(
	parameter int unsigned PRIORITY_BITS = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,

	// Trap pulses from the core
	input  wire                          trap_enter,
	input  wire                          trap_enter_is_eirq,
	input  wire                          trap_exit,

	// Register writes
	input  wire                          wr_en,
	input  wire irqc_pkg::csr_addr_e     wr_addr,
	input  wire irqc_pkg::csr_wdata_u    wr_data,

	// Selector results
	input  wire                          next_noirq,
	input  wire [8:0]                    next_irq,
	input  wire [4:0]                    next_preempt,

	output irqc_pkg::irq_ctx_t           ctx
);

	localparam logic [3:0] prio_mask = ~(4'hf >> PRIORITY_BITS);

	logic ctx_write;
	logic meinext_update;

	assign ctx_write      = wr_en && wr_addr == irqc_pkg::meicontext;
	// Bit 0 of a meinext write asks to take the reported interrupt
	assign meinext_update = wr_en && wr_addr == irqc_pkg::meinext && wr_data.ctx.mreteirq;

	// -----------------------------------------------
	// Context update

	// Trap pulses come first, then software writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctx          <= '0;
			ctx.noirq    <= 1'b1;
		end else if (trap_enter) begin
			if (trap_enter_is_eirq) begin
				// Push the levels down one slot. The top bit of preempt is
				// clear here, since a level of 16 blocks every interrupt
				ctx.pppreempt <= ctx.ppreempt & prio_mask;
				ctx.ppreempt  <= ctx.preempt[3:0] & prio_mask;
				ctx.preempt   <= next_preempt & {1'b1, prio_mask};
				ctx.mreteirq  <= 1'b1;
			end else begin
				// Some other trap, so the next mret does not pop
				ctx.mreteirq  <= 1'b0;
			end
		end else if (trap_exit) begin
			ctx.mreteirq <= 1'b0;
			if (ctx.mreteirq) begin
				// Pop the saved levels back up
				ctx.pppreempt <= 4'h0;
				ctx.ppreempt  <= ctx.pppreempt & prio_mask;
				ctx.preempt   <= {1'b0, ctx.ppreempt & prio_mask};
			end
		end else if (ctx_write) begin
			ctx.pppreempt <= wr_data.ctx.pppreempt & prio_mask;
			ctx.ppreempt  <= wr_data.ctx.ppreempt & prio_mask;
			ctx.preempt   <= wr_data.ctx.preempt & {1'b1, prio_mask};
			ctx.noirq     <= wr_data.ctx.noirq;
			ctx.irq       <= wr_data.ctx.irq;
			ctx.mreteirq  <= wr_data.ctx.mreteirq;
		end else if (meinext_update) begin
			// The handler has sampled its interrupt, raise the level to match
			ctx.preempt <= next_preempt & {1'b1, prio_mask};
			ctx.noirq   <= next_noirq;
			ctx.irq     <= next_irq;
		end
	end

endmodule

`default_nettype wire

//--- irq_regfile/irq_regfile.sv
// -----------------------------------------------
// Interrupt line registers and per-line arrays
// Input flops, enable, force and priority with
// windowed write and read
// -----------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irq_regfile #(
	parameter int unsigned NUM_IRQS      = 32,
	parameter int unsigned PRIORITY_BITS = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [NUM_IRQS-1:0]           irq,

	// Write strobes from the port
	input  wire                          wr_en,
	input  wire irqc_pkg::csr_addr_e     wr_addr,
	input  wire irqc_pkg::csr_wdata_u    wr_data,
	input  wire                          meinext_rd,
	input  wire                          next_noirq,
	input  wire [8:0]                    next_irq,

	// Read window
	input  wire irqc_pkg::csr_addr_e     rd_addr,
	input  wire [6:0]                    rd_index,
	output logic [irqc_pkg::data_w-1:0]  rdata,

	output logic [NUM_IRQS-1:0]          enable,
	output logic [NUM_IRQS-1:0]          pending,
	output logic [NUM_IRQS-1:0][3:0]     prio
);

	// Priority bits are kept MSB-aligned, the low bits are not implemented
	localparam logic [3:0] prio_mask = ~(4'hf >> PRIORITY_BITS);

	logic [NUM_IRQS-1:0] irq_r;
	logic [NUM_IRQS-1:0] force_bits;

	logic [irqc_pkg::max_irqs-1:0]      enable_pad;
	logic [irqc_pkg::max_irqs-1:0]      pending_pad;
	logic [irqc_pkg::max_irqs-1:0]      force_pad;
	logic [irqc_pkg::max_irqs-1:0][3:0] prio_pad;

	// -----------------------------------------------
	// Line input flops

	// One register stage keeps the lines away from the port read path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r <= '0;
		end else begin
			irq_r <= irq;
		end
	end

	// A line is pending when it is high or when software forces it
	assign pending = irq_r | force_bits;

	// -----------------------------------------------
	// Array writes

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable     <= '0;
			force_bits <= '0;
			prio       <= '0;
		end else begin
			for (int i = 0; i < NUM_IRQS; i++) begin
				// Sixteen enable or force bits per window
				if (wr_en && wr_addr == irqc_pkg::meiea && wr_data.win.index[4:0] == 5'(i / 16)) begin
					enable[i] <= wr_data.win.data[i % 16];
				end
				if (wr_en && wr_addr == irqc_pkg::meifa && wr_data.win.index[4:0] == 5'(i / 16)) begin
					force_bits[i] <= wr_data.win.data[i % 16];
				end
				// Four priority fields per window
				if (wr_en && wr_addr == irqc_pkg::meipra && wr_data.win.index == 7'(i / 4)) begin
					prio[i] <= wr_data.win.data[4 * (i % 4) +: 4] & prio_mask;
				end
				// Reading meinext takes the reported line, so a forced line
				// fires once without touching the source
				if (meinext_rd && !next_noirq && next_irq == 9'(i)) begin
					force_bits[i] <= 1'b0;
				end
			end
		end
	end

	// -----------------------------------------------
	// Windowed read

	// Lines above NUM_IRQS read back as zero
	always_comb begin
		enable_pad                  = '0;
		pending_pad                 = '0;
		force_pad                   = '0;
		prio_pad                    = '0;
		enable_pad[NUM_IRQS-1:0]    = enable;
		pending_pad[NUM_IRQS-1:0]   = pending;
		force_pad[NUM_IRQS-1:0]     = force_bits;
		prio_pad[NUM_IRQS-1:0]      = prio;
	end

	always_comb begin
		case (rd_addr)
			irqc_pkg::meiea:  rdata = {enable_pad[rd_index[4:0] * 16 +: 16], 16'h0};
			irqc_pkg::meipa:  rdata = {pending_pad[rd_index[4:0] * 16 +: 16], 16'h0};
			irqc_pkg::meifa:  rdata = {force_pad[rd_index[4:0] * 16 +: 16], 16'h0};
			irqc_pkg::meipra: rdata = {prio_pad[rd_index * 4 +: 4], 16'h0};
			default:          rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- irqc_top.f
common/irqc_pkg.sv
rtl/irqc_csr_port.sv
irq_regfile/irq_regfile.sv
irq_context/irq_context.sv
rtl/irq_select.sv
rtl/irqc_top.sv
verif/irqc_clkgen.sv
verif/irqc_checker.sv
verif/irqc_assertions.sv
verif/irqc_tb.sv

//--- rtl/irq_select.sv
// -----------------------------------------------
// Interrupt selection
// Preemption masks, highest-priority pick and the
// next preemption level
// -----------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irq_select #(
	parameter int unsigned NUM_IRQS      = 32,
	parameter int unsigned PRIORITY_BITS = 4
) (
	input  wire [NUM_IRQS-1:0]           pending,
	input  wire [NUM_IRQS-1:0]           enable,
	input  wire [NUM_IRQS-1:0][3:0]      prio,
	input  wire irqc_pkg::irq_ctx_t      ctx,

	output logic                         external_irq_pending,
	output logic                         next_noirq,
	output logic [8:0]                   next_irq,
	output logic [4:0]                   next_preempt
);

	// One step of the implemented priority width, counted at 4 bits
	localparam logic [4:0] prio_step = 5'd1 << (4 - PRIORITY_BITS);

	logic [NUM_IRQS-1:0] above_preempt;
	logic [NUM_IRQS-1:0] above_ppreempt;
	logic                found;
	logic [3:0]          best_prio;
	logic [8:0]          best_irq;

	// -----------------------------------------------
	// Preemption masks

	// The trap request looks at the current level. meinext looks at the
	// previous one, so a handler does not see the frames it preempted
	always_comb begin
		for (int i = 0; i < NUM_IRQS; i++) begin
			above_preempt[i]  = pending[i] && enable[i] && {1'b0, prio[i]} >= ctx.preempt;
			above_ppreempt[i] = pending[i] && enable[i] && prio[i] >= ctx.ppreempt;
		end
	end

	assign external_irq_pending = |above_preempt;

	// -----------------------------------------------
	// Highest-priority pick

	// Only a strictly higher priority replaces the current best, so the
	// lowest index wins a tie
	always_comb begin
		found     = 1'b0;
		best_prio = 4'h0;
		best_irq  = 9'h0;
		for (int i = 0; i < NUM_IRQS; i++) begin
			if (above_ppreempt[i] && (!found || prio[i] > best_prio)) begin
				found     = 1'b1;
				best_prio = prio[i];
				best_irq  = 9'(i);
			end
		end
	end

	assign next_noirq = !found;
	assign next_irq   = best_irq & {9{found}};

	// Level 16 blocks everything, used when nothing qualifies
	assign next_preempt = found ? prio_step + {1'b0, best_prio} : 5'h10;

endmodule

`default_nettype wire

//--- rtl/irqc_csr_port.sv
// -----------------------------------------------
// Register port front end of the interrupt controller
// Accepts requests, drives write strobes, muxes
// read data and holds the response
// -----------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_csr_port (
	input  wire                          clk,
	input  wire                          rst_n,

	// Request and response channels
	input  wire irqc_pkg::csr_req_t      req,
	input  wire                          req_valid,
	output logic                         req_ready,
	output irqc_pkg::csr_rsp_t           rsp,
	output logic                         rsp_valid,
	input  wire                          rsp_ready,

	// Read sources
	input  wire [irqc_pkg::data_w-1:0]   regfile_rdata,
	input  wire irqc_pkg::irq_ctx_t      ctx,
	input  wire                          next_noirq,
	input  wire [8:0]                    next_irq,

	// Strobes to the register file and the context
	output logic                         wr_en,
	output irqc_pkg::csr_addr_e          wr_addr,
	output irqc_pkg::csr_wdata_u         wr_data,
	output logic                         meinext_rd
);

	logic                        accept;
	logic [irqc_pkg::data_w-1:0] rd_data;
	irqc_pkg::csr_wdata_u        ctx_word;

	// A new request waits only while an old response is still held
	assign req_ready = !(rsp_valid && !rsp_ready);
	assign accept    = req_valid && req_ready;

	// Strobes act at the same edge that accepts the request
	assign wr_en      = accept && req.write;
	assign wr_addr    = req.addr;
	assign wr_data    = req.data;
	assign meinext_rd = accept && !req.write && req.addr == irqc_pkg::meinext;

	// -----------------------------------------------
	// Read data

	always_comb begin
		// Pack the context into its register layout, unused bits read zero
		ctx_word                = '0;
		ctx_word.ctx.pppreempt  = ctx.pppreempt;
		ctx_word.ctx.ppreempt   = ctx.ppreempt;
		ctx_word.ctx.preempt    = ctx.preempt;
		ctx_word.ctx.noirq      = ctx.noirq;
		ctx_word.ctx.irq        = ctx.irq;
		ctx_word.ctx.mreteirq   = ctx.mreteirq;

		case (req.addr)
			irqc_pkg::meiea, irqc_pkg::meipa, irqc_pkg::meifa, irqc_pkg::meipra: begin
				rd_data = regfile_rdata;
			end
			irqc_pkg::meinext: begin
				// noirq sits in the sign bit so software can test it cheaply
				rd_data = {next_noirq, 20'h0, next_irq, 2'h0};
			end
			irqc_pkg::meicontext: begin
				rd_data = ctx_word;
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	// -----------------------------------------------
	// Response register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else if (accept) begin
			rsp_valid <= 1'b1;
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;
		end
	end

	// Data captures the value from before the access and stays put until
	// the next accepted request
	always_ff @(posedge clk) begin
		if (accept) begin
			rsp.rdata <= rd_data;
		end
	end

endmodule

`default_nettype wire

//--- rtl/irqc_top.sv
// -----------------------------------------------
// External interrupt controller top level
// Port, register file, context and selector
// -----------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_top #(
	parameter int unsigned NUM_IRQS      = 32,
	parameter int unsigned PRIORITY_BITS = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,

	input  wire irqc_pkg::csr_req_t      req,
	input  wire                          req_valid,
	output logic                         req_ready,
	output irqc_pkg::csr_rsp_t           rsp,
	output logic                         rsp_valid,
	input  wire                          rsp_ready,

	input  wire [NUM_IRQS-1:0]           irq,
	input  wire                          trap_enter,
	input  wire                          trap_enter_is_eirq,
	input  wire                          trap_exit,
	output logic                         external_irq_pending
);

	// Port strobes
	logic                        wr_en;
	irqc_pkg::csr_addr_e         wr_addr;
	irqc_pkg::csr_wdata_u        wr_data;
	logic                        meinext_rd;
	logic [irqc_pkg::data_w-1:0] regfile_rdata;

	// Line state and selection
	logic [NUM_IRQS-1:0]         enable;
	logic [NUM_IRQS-1:0]         pending;
	logic [NUM_IRQS-1:0][3:0]    prio;
	irqc_pkg::irq_ctx_t          ctx;
	logic                        next_noirq;
	logic [8:0]                  next_irq;
	logic [4:0]                  next_preempt;

	irqc_csr_port csr_port_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.req_valid     (req_valid),
		.req_ready     (req_ready),
		.rsp           (rsp),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.regfile_rdata (regfile_rdata),
		.ctx           (ctx),
		.next_noirq    (next_noirq),
		.next_irq      (next_irq),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.meinext_rd    (meinext_rd)
	);

	// Reads use the same decoded address and window as the write strobes
	irq_regfile #(
		.NUM_IRQS      (NUM_IRQS),
		.PRIORITY_BITS (PRIORITY_BITS)
	) regfile_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.irq        (irq),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.meinext_rd (meinext_rd),
		.next_noirq (next_noirq),
		.next_irq   (next_irq),
		.rd_addr    (wr_addr),
		.rd_index   (wr_data.win.index),
		.rdata      (regfile_rdata),
		.enable     (enable),
		.pending    (pending),
		.prio       (prio)
	);

	irq_context #(
		.PRIORITY_BITS (PRIORITY_BITS)
	) context_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.trap_enter         (trap_enter),
		.trap_enter_is_eirq (trap_enter_is_eirq),
		.trap_exit          (trap_exit),
		.wr_en              (wr_en),
		.wr_addr            (wr_addr),
		.wr_data            (wr_data),
		.next_noirq         (next_noirq),
		.next_irq           (next_irq),
		.next_preempt       (next_preempt),
		.ctx                (ctx)
	);

	irq_select #(
		.NUM_IRQS      (NUM_IRQS),
		.PRIORITY_BITS (PRIORITY_BITS)
	) select_i (
		.pending              (pending),
		.enable               (enable),
		.prio                 (prio),
		.ctx                  (ctx),
		.external_irq_pending (external_irq_pending),
		.next_noirq           (next_noirq),
		.next_irq             (next_irq),
		.next_preempt         (next_preempt)
	);

endmodule

`default_nettype wire

//--- verif/irqc_assertions.sv
// --------------------------------------------------
// Assertions bound to the register port
// Response hold under back-pressure and reset values
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_assertions (
	input wire                     clk,
	input wire                     rst_n,
	input wire irqc_pkg::csr_rsp_t rsp,
	input wire                     rsp_valid,
	input wire                     rsp_ready,
	input wire                     req_ready
);

	// A response that is not taken stays valid and unchanged
	held_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("held response changed");

	// While a held response waits, the request port stays blocked
	held_blocks_req: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_ready || !req_ready)
		else $error("req_ready high under back-pressure");

	// In reset the port is idle and ready
	reset_values: assert property (@(posedge clk)
		!rst_n |-> !rsp_valid && req_ready)
		else $error("wrong port values in reset");

endmodule

`default_nettype wire

//--- verif/irqc_checker.sv
// --------------------------------------------------
// Response checker of the interrupt controller testbench
// Compares read data and external_irq_pending with
// expected values and counts the results
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_checker (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire irqc_pkg::csr_rsp_t rsp,
	input  wire                     rsp_valid,
	input  wire                     rsp_ready,
	input  wire                     req_ready,
	input  wire                     external_irq_pending,
	input  wire [31:0]              exp_rdata,
	input  wire                     exp_pend,
	input  wire [3:0]               test_num,
	input  wire                     done,
	output int                      error_count,
	output int                      check_count
);

	// Values are sampled at the rising edge, the testbench drives on the falling one
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			error_count <= 0;
			check_count <= 0;
		end else if (rsp_valid && !rsp_ready) begin
			// A held response must block new requests
			if (req_ready) begin
				$display("Test %0d: request port was ready while a response was held",
					test_num);
				error_count <= error_count + 1;
			end
		end else if (rsp_valid && rsp_ready) begin
			check_count <= check_count + 1;
			if (rsp.rdata !== exp_rdata) begin
				$display("[ERROR] test %0d rsp.rdata expected %h got %h",
					test_num, exp_rdata, rsp.rdata);
				error_count <= error_count + 1;
			end
			if (external_irq_pending !== exp_pend) begin
				$display("[ERROR] test %0d external_irq_pending expected %h got %h",
					test_num, exp_pend, external_irq_pending);
				error_count <= error_count + 1;
			end
			if (rsp.rdata === exp_rdata && external_irq_pending === exp_pend) begin
				$display("Test %0d step done: match, rdata %h", test_num, rsp.rdata);
			end else begin
				$display("Test %0d step done: mismatch", test_num);
			end
		end
	end

	// Closing summary once the table is used up
	always @(posedge done) begin
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
	end

endmodule

`default_nettype wire

//--- verif/irqc_clkgen.sv
// --------------------------------------------------
// Testbench clock and reset source
// 20 ns clock, active-low reset held for 8 cycles
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset falls just after time zero so the flops see a clean edge
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/irqc_tb.sv
// --------------------------------------------------
// Testbench top of the interrupt controller
// Stimulus table, falling-edge driver, DUT instance,
// checker and bound assertions
// --------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module irqc_tb;

	localparam int timeout_cycles = 50;

	typedef struct packed {
		irqc_pkg::csr_req_t req;
		logic [31:0]        irq;
		logic               trap_enter;
		logic               is_eirq;
		logic               trap_exit;
		logic [3:0]         hold;
		logic [31:0]        exp_rdata;
		logic               exp_pend;
		logic [3:0]         test;
	} step_t;

	logic clk;
	logic rst_n;
	irqc_pkg::csr_req_t req;
	logic               req_valid;
	logic               req_ready;
	irqc_pkg::csr_rsp_t rsp;
	logic               rsp_valid;
	logic               rsp_ready;
	logic [31:0]        irq;
	logic               trap_enter;
	logic               trap_enter_is_eirq;
	logic               trap_exit;
	logic               external_irq_pending;
	logic [31:0]        exp_rdata;
	logic               exp_pend;
	logic [3:0]         test_num;
	logic               done;
	int                 error_count;
	int                 check_count;

	step_t steps[$];

	// Reference line state for the random steps
	logic [31:0]      model_en;
	logic [31:0][3:0] model_prio;

	irqc_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

	irqc_top #(
		.NUM_IRQS      (32),
		.PRIORITY_BITS (4)
	) irqc_top_i (
		.clk                  (clk),
		.rst_n                (rst_n),
		.req                  (req),
		.req_valid            (req_valid),
		.req_ready            (req_ready),
		.rsp                  (rsp),
		.rsp_valid            (rsp_valid),
		.rsp_ready            (rsp_ready),
		.irq                  (irq),
		.trap_enter           (trap_enter),
		.trap_enter_is_eirq   (trap_enter_is_eirq),
		.trap_exit            (trap_exit),
		.external_irq_pending (external_irq_pending)
	);

	irqc_checker checker_i (
		.clk(clk), .rst_n(rst_n), .rsp(rsp), .rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready), .req_ready(req_ready),
		.external_irq_pending(external_irq_pending), .exp_rdata(exp_rdata),
		.exp_pend(exp_pend), .test_num(test_num), .done(done),
		.error_count(error_count), .check_count(check_count)
	);

	bind irqc_csr_port irqc_assertions assertions_i (
		.clk(clk), .rst_n(rst_n), .rsp(rsp), .rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready), .req_ready(req_ready)
	);

	// --------------------------------------------------
	// Table helpers

	// Array window word with data on top and the index at the bottom
	function automatic logic [31:0] win_word(logic [15:0] data, logic [6:0] idx);
		return {data, 9'h0, idx};
	endfunction

	function automatic void add(logic [3:0] test, irqc_pkg::csr_addr_e addr, logic write,
		logic [31:0] data, logic [31:0] irqv, logic [2:0] traps, logic [3:0] hold,
		logic [31:0] exp, logic pend);
		step_t s;
		s.req.addr   = addr;
		s.req.write  = write;
		s.req.data   = data;
		s.irq        = irqv;
		s.trap_enter = traps[2];
		s.is_eirq    = traps[1];
		s.trap_exit  = traps[0];
		s.hold       = hold;
		s.exp_rdata  = exp;
		s.exp_pend   = pend;
		s.test       = test;
		steps.push_back(s);
	endfunction

	// Highest priority wins and the lowest index breaks a tie
	// The no-interrupt flag sits in the sign bit
	function automatic logic [31:0] expect_meinext(logic [31:0] irqv);
		logic       found;
		logic [3:0] best;
		logic [8:0] line;
		found = 1'b0;
		best  = 4'h0;
		line  = 9'h0;
		for (int i = 0; i < 32; i++) begin
			if (irqv[i] && model_en[i] && (!found || model_prio[i] > best)) begin
				found = 1'b1;
				best  = model_prio[i];
				line  = 9'(i);
			end
		end
		return {!found, 20'h0, line, 2'h0};
	endfunction

	task automatic build_table();
		logic [31:0] r;
		// Test 1 writes and reads array windows
		add(1, irqc_pkg::meiea, 1, win_word(16'h00f0, 0), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meiea, 0, win_word(16'h0, 0), 0, 3'b000, 0, 32'h00f0_0000, 0);
		add(1, irqc_pkg::meiea, 0, win_word(16'h0, 1), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meiea, 1, win_word(16'h8001, 1), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meiea, 0, win_word(16'h0, 1), 0, 3'b000, 0, 32'h8001_0000, 0);
		add(1, irqc_pkg::meipra, 1, win_word(16'h3a52, 1), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meipra, 0, win_word(16'h0, 1), 0, 3'b000, 0, 32'h3a52_0000, 0);
		add(1, irqc_pkg::meipra, 0, win_word(16'h0, 0), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meifa, 1, win_word(16'h0100, 0), 0, 3'b000, 0, 32'h0, 0);
		add(1, irqc_pkg::meifa, 0, win_word(16'h0, 0), 0, 3'b000, 0, 32'h0100_0000, 0);
		add(1, irqc_pkg::meifa, 1, win_word(16'h0, 0), 0, 3'b000, 0, 32'h0100_0000, 0);
		// Test 2 selects among lines 4 to 7, 16 and 31
		add(2, irqc_pkg::meinext, 0, 0, 32'hb0, 3'b000, 0, 32'h14, 1);
		add(2, irqc_pkg::meinext, 0, 0, 32'h68, 3'b000, 0, 32'h18, 1);
		add(2, irqc_pkg::meinext, 0, 0, 32'h8001_0000, 3'b000, 0, 32'h40, 1);
		add(2, irqc_pkg::meinext, 0, 0, 32'h0002_0300, 3'b000, 0, 32'h8000_0000, 0);
		for (int k = 0; k < 6; k++) begin
			r = $urandom();
			add(2, irqc_pkg::meinext, 0, 0, r, 3'b000, 0, expect_meinext(r),
				|(r & model_en));
		end
		// Test 3 forces lines and takes them with meinext reads
		add(3, irqc_pkg::meifa, 1, win_word(16'h0020, 0), 0, 3'b000, 0, 32'h0, 1);
		add(3, irqc_pkg::meifa, 1, win_word(16'h0001, 1), 0, 3'b000, 0, 32'h0, 1);
		add(3, irqc_pkg::meipa, 0, win_word(16'h0, 0), 0, 3'b000, 0, 32'h0020_0000, 1);
		add(3, irqc_pkg::meinext, 0, 0, 0, 3'b000, 0, 32'h14, 1);
		add(3, irqc_pkg::meinext, 0, 0, 0, 3'b000, 0, 32'h40, 0);
		add(3, irqc_pkg::meinext, 0, 0, 0, 3'b000, 0, 32'h8000_0000, 0);
		// Test 4 pushes on trap entry and pops once on trap exit
		add(4, irqc_pkg::meicontext, 0, 0, 32'h50, 3'b000, 0, 32'h0000_8000, 1);
		add(4, irqc_pkg::meicontext, 0, 0, 32'h50, 3'b110, 0, 32'h000b_8001, 0);
		add(4, irqc_pkg::meipra, 1, win_word(16'hfa52, 1), 32'hd0, 3'b000, 0,
			32'h3a52_0000, 1);
		add(4, irqc_pkg::meicontext, 0, 0, 32'hd0, 3'b110, 0, 32'h0b10_8001, 0);
		add(4, irqc_pkg::meicontext, 0, 0, 32'hd0, 3'b001, 0, 32'h000b_8000, 1);
		add(4, irqc_pkg::meicontext, 0, 0, 32'hd0, 3'b001, 0, 32'h000b_8000, 1);
		add(4, irqc_pkg::meicontext, 1, 0, 32'hd0, 3'b000, 0, 32'h000b_8000, 1);
		// Test 5 writes meinext with and without the update bit
		add(5, irqc_pkg::meinext, 1, 32'h1, 32'h50, 3'b000, 0, 32'h18, 0);
		add(5, irqc_pkg::meicontext, 0, 0, 32'h50, 3'b000, 0, 32'h000b_0060, 0);
		add(5, irqc_pkg::meinext, 1, 32'h1, 0, 3'b000, 0, 32'h8000_0000, 0);
		add(5, irqc_pkg::meicontext, 0, 0, 0, 3'b000, 0, 32'h0010_8000, 0);
		add(5, irqc_pkg::meinext, 1, 32'h0, 32'h50, 3'b000, 0, 32'h18, 0);
		add(5, irqc_pkg::meicontext, 0, 0, 32'h50, 3'b000, 0, 32'h0010_8000, 0);
		add(5, irqc_pkg::meicontext, 1, 0, 0, 3'b000, 0, 32'h0010_8000, 0);
		// Test 6 holds the response under back-pressure
		add(6, irqc_pkg::meiea, 0, win_word(16'h0, 0), 0, 3'b000, 3, 32'h00f0_0000, 0);
		add(6, irqc_pkg::meipra, 0, win_word(16'h0, 1), 0, 3'b000, 0, 32'hfa52_0000, 0);
	endtask

	// --------------------------------------------------
	// Driver

	task automatic apply_step(input step_t s, output bit ok);
		int cnt;
		ok = 1'b1;
		// Lines and trap pulses go first so that the request sees their effect
		@(negedge clk);
		irq                = s.irq;
		trap_enter         = s.trap_enter;
		trap_enter_is_eirq = s.is_eirq;
		trap_exit          = s.trap_exit;
		exp_rdata          = s.exp_rdata;
		exp_pend           = s.exp_pend;
		test_num           = s.test;
		@(negedge clk);
		trap_enter         = 1'b0;
		trap_enter_is_eirq = 1'b0;
		trap_exit          = 1'b0;
		req                = s.req;
		req_valid          = 1'b1;
		rsp_ready          = (s.hold == 0);
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (!req_ready && cnt < timeout_cycles);
		if (!req_ready) begin
			$display("Timeout: request of test %0d was never accepted", s.test);
			ok = 1'b0;
			return;
		end
		@(negedge clk);
		req_valid = 1'b0;
		repeat (s.hold) @(negedge clk);
		rsp_ready = 1'b1;
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (!(rsp_valid && rsp_ready) && cnt < timeout_cycles);
		if (!(rsp_valid && rsp_ready)) begin
			$display("Timeout: no response for test %0d", s.test);
			ok = 1'b0;
		end
	endtask

	initial begin
		bit ok;
		int cnt;
		req                = '0;
		req_valid          = 1'b0;
		rsp_ready          = 1'b1;
		irq                = '0;
		trap_enter         = 1'b0;
		trap_enter_is_eirq = 1'b0;
		trap_exit          = 1'b0;
		exp_rdata          = '0;
		exp_pend           = 1'b0;
		test_num           = '0;
		done               = 1'b0;
		ok                 = 1'b1;
		void'($urandom(32'h24fd));
		model_en   = 32'h8001_00f0;
		model_prio = '0;
		model_prio[4] = 4'h2;
		model_prio[5] = 4'h5;
		model_prio[6] = 4'ha;
		model_prio[7] = 4'h3;
		build_table();
		// Reset is released on a falling edge, so it is watched on rising edges
		cnt = 0;
		do begin
			@(posedge clk);
			cnt++;
		end while (rst_n !== 1'b1 && cnt < timeout_cycles);
		if (rst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			ok = 1'b0;
		end
		foreach (steps[i]) begin
			if (ok) begin
				apply_step(steps[i], ok);
			end
		end
		done = 1'b1;
		@(negedge clk);
		if (ok && error_count == 0 && check_count == steps.size()) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
